// ==== Bender.yml ====
package:
  name: trig_xbar

sources:
  # Packages first
  - apb_defs_pkg.sv
  - xbar_types_pkg.sv
  # Design
  - xbar_apb_regs.sv
  - xbar_input_stage.sv
  - xbar_out_channel.sv
  - xbar_output_stage.sv
  - trig_xbar_top.sv
  # Testbench, top module tb_trig_xbar
  - target: test
    files:
      - tb_trig_xbar.sv

// ==== apb_defs_pkg.sv ====
package apb_defs_pkg;

	//////////////////////////////////////////////////
	// Bus widths

	// Byte address width of the completer
	localparam int apb_addr_width = 8;

	// Completer is 16-bit only
	localparam int apb_data_width = 16;

	typedef logic [apb_addr_width-1:0] apb_addr_t;
	typedef logic [apb_data_width-1:0] apb_data_t;

	//////////////////////////////////////////////////
	// Register map

	// One 16-bit register per output, so the index starts above bit 0
	localparam int reg_idx_lsb = 1;

	// Highest register address, muxsel11
	localparam apb_addr_t reg_last_addr = 8'h16;

endpackage

// ==== tb_trig_xbar.sv ====
`timescale 1ns/1ps

module tb_trig_xbar
	import apb_defs_pkg::*;
	import xbar_types_pkg::*;
();

	//////////////////////////////////////////////////
	// DUT signals

	logic      apb;
	logic      rst_n;
	apb_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_data_t pwdata;
	logic      pready;
	apb_data_t prdata;
	logic      pslverr;
	port_vec_t trig_in;
	port_vec_t trig_out;
	port_vec_t trig_in_led;
	port_vec_t trig_out_led;

	trig_xbar_top u_dut (
		.apb          (apb),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.pready       (pready),
		.prdata       (prdata),
		.pslverr      (pslverr),
		.trig_in      (trig_in),
		.trig_out     (trig_out),
		.trig_in_led  (trig_in_led),
		.trig_out_led (trig_out_led)
	);

	// 8 ns clock
	initial begin
		apb = 1'b0;
		forever #4 apb = ~apb;
	end

	//////////////////////////////////////////////////
	// Test table

	// Row kinds
	localparam int op_rst  = 0;
	localparam int op_wr   = 1;
	localparam int op_rd   = 2;
	localparam int op_trig = 3;
	localparam int op_led  = 4;

	string     t_name [$];
	int        t_op   [$];
	apb_addr_t t_addr [$];
	apb_data_t t_data [$];
	apb_data_t t_exp  [$];
	logic      t_err  [$];

	// Expected select map, kept from accepted writes
	muxsel_t   sel_model [num_ports];

	logic [31:0] lfsr_q;
	int          err_cnt;
	int          test_err;
	int          check_cnt;
	int          cycle_cnt;
	int          cycle_limit;

	task automatic add_row(input string name, input int op, input apb_addr_t addr,
		input apb_data_t data, input apb_data_t exp, input logic err);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_exp.push_back(exp);
		t_err.push_back(err);
	endtask

	//////////////////////////////////////////////////
	// Helpers

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_cnt++;
		if (expected !== actual) begin
			err_cnt++;
			test_err++;
			$display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per pattern bit
	task automatic next_pattern(output port_vec_t pat);
		for (int i = 0; i < num_ports; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			pat[i] = lfsr_q[0];
		end
	endtask

	// Output i follows input sel-1, low when off
	function automatic port_vec_t route_model(input port_vec_t pat);
		port_vec_t exp;
		exp = '0;
		for (int o = 0; o < num_ports; o++) begin
			if (sel_model[o] != 4'd0)
				exp[o] = pat[sel_model[o] - 1];
		end
		return exp;
	endfunction

	// Setup phase, access phase, then idle
	task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		int waits;
		waits = 0;
		@(negedge apb);
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge apb);
		penable = 1'b1;
		@(posedge apb);
		while (!pready && waits < 8) begin
			waits++;
			@(posedge apb);
		end
		// Pre-edge values, settled since the falling edge
		rdata = prdata;
		err   = pslverr;
		if (!pready) begin
			err_cnt++;
			test_err++;
			$display("APB transfer to address 0x%02h never saw pready", addr);
		end
		@(negedge apb);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Row runners

	task automatic run_reset_row(input string name);
		apb_data_t rd;
		logic      err;
		check_val({name, " trig_out"}, 0, trig_out);
		check_val({name, " trig_in_led"}, 0, trig_in_led);
		check_val({name, " trig_out_led"}, 0, trig_out_led);
		check_val({name, " pready idle"}, 0, pready);
		check_val({name, " pslverr idle"}, 0, pslverr);
		// Every select comes up off
		for (int i = 0; i < num_ports; i++) begin
			apb_xfer(apb_addr_t'(2 * i), 1'b0, '0, rd, err);
			check_val($sformatf("%s sel%0d", name, i), 0, rd);
			check_val($sformatf("%s sel%0d pslverr", name, i), 0, err);
		end
	endtask

	task automatic run_trig_row(input string name);
		port_vec_t pat;
		next_pattern(pat);
		@(negedge apb);
		trig_in = pat;
		// Two sync stages plus the lane register
		repeat (3) @(negedge apb);
		check_val($sformatf("%s pattern 0x%03h", name, pat), route_model(pat), trig_out);
		// Fourth cycle of the hold
		@(negedge apb);
	endtask

	task automatic run_led_row(input string name, input int src);
		port_vec_t exp_out;
		int        in_lit  [num_ports];
		int        out_lit [num_ports];
		logic      ok;
		@(negedge apb);
		trig_in = '0;
		// Let earlier activity fade
		repeat (led_hold + 10) @(negedge apb);
		check_val({name, " in_led idle"}, 0, trig_in_led);
		check_val({name, " out_led idle"}, 0, trig_out_led);
		exp_out = '0;
		for (int o = 0; o < num_ports; o++) begin
			in_lit[o]  = 0;
			out_lit[o] = 0;
			if (sel_model[o] == muxsel_t'(src + 1))
				exp_out[o] = 1'b1;
		end
		// Single-cycle pulse
		trig_in[src] = 1'b1;
		@(negedge apb);
		trig_in = '0;
		for (int n = 0; n < led_hold + 10; n++) begin
			@(negedge apb);
			for (int i = 0; i < num_ports; i++) begin
				if (trig_in_led[i])
					in_lit[i]++;
				if (trig_out_led[i])
					out_lit[i]++;
			end
		end
		// Lit ones last the hold time, the rest stay dark
		for (int i = 0; i < num_ports; i++) begin
			if (i == src)
				ok = (in_lit[i] >= led_hold) && (in_lit[i] <= led_hold + 5);
			else
				ok = (in_lit[i] == 0);
			check_val($sformatf("%s in_led%0d lit %0d cycles", name, i, in_lit[i]), 1, ok);
			if (exp_out[i])
				ok = (out_lit[i] >= led_hold) && (out_lit[i] <= led_hold + 5);
			else
				ok = (out_lit[i] == 0);
			check_val($sformatf("%s out_led%0d lit %0d cycles", name, i, out_lit[i]), 1, ok);
		end
		check_val({name, " in_led dark"}, 0, trig_in_led);
		check_val({name, " out_led dark"}, 0, trig_out_led);
	endtask

	//////////////////////////////////////////////////
	// Cycle limit

	always @(posedge apb) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Run stopped after %0d cycles before all tests finished", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		apb_data_t rd;
		logic      err;
		int        test_cnt;
		rst_n       = 1'b0;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		trig_in     = '0;
		lfsr_q      = 32'hcdc1;
		err_cnt     = 0;
		test_err    = 0;
		check_cnt   = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		test_cnt    = 0;
		for (int i = 0; i < num_ports; i++)
			sel_model[i] = 4'd0;

		// Reset and basic readback
		add_row("reset_state",  op_rst, 8'h00, 16'd0, 16'd0, 1'b0);
		add_row("wr_sel0",      op_wr,  8'h00, 16'd3, 16'd0, 1'b0);
		add_row("rd_sel0",      op_rd,  8'h00, 16'd0, 16'd3, 1'b0);
		add_row("wr_sel5",      op_wr,  8'h0a, 16'd12, 16'd0, 1'b0);
		add_row("rd_sel5",      op_rd,  8'h0a, 16'd0, 16'd12, 1'b0);
		add_row("wr_sel11",     op_wr,  8'h16, 16'd1, 16'd0, 1'b0);
		add_row("rd_sel11",     op_rd,  8'h16, 16'd0, 16'd1, 1'b0);
		// Error responses leave registers alone
		add_row("wr_unaligned", op_wr,  8'h03, 16'd5, 16'd0, 1'b1);
		add_row("rd_sel1_kept", op_rd,  8'h02, 16'd0, 16'd0, 1'b0);
		add_row("rd_unaligned", op_rd,  8'h01, 16'd0, 16'd0, 1'b1);
		add_row("wr_idx12",     op_wr,  8'h18, 16'd2, 16'd0, 1'b1);
		add_row("rd_idx12",     op_rd,  8'h18, 16'd0, 16'd0, 1'b1);
		add_row("wr_idx_top",   op_wr,  8'hfe, 16'd1, 16'd0, 1'b1);
		add_row("wr_val13",     op_wr,  8'h00, 16'd13, 16'd0, 1'b1);
		add_row("rd_sel0_kept", op_rd,  8'h00, 16'd0, 16'd3, 1'b0);
		add_row("wr_val_max",   op_wr,  8'h0a, 16'hffff, 16'd0, 1'b1);
		add_row("rd_sel5_kept", op_rd,  8'h0a, 16'd0, 16'd12, 1'b0);
		// Routing map, inputs 2, 6 and 0 shared
		add_row("wr_sel2",      op_wr,  8'h04, 16'd3, 16'd0, 1'b0);
		add_row("wr_sel3",      op_wr,  8'h06, 16'd7, 16'd0, 1'b0);
		add_row("wr_sel4",      op_wr,  8'h08, 16'd3, 16'd0, 1'b0);
		add_row("wr_sel6_on",   op_wr,  8'h0c, 16'd5, 16'd0, 1'b0);
		add_row("wr_sel6_off",  op_wr,  8'h0c, 16'd0, 16'd0, 1'b0);
		add_row("rd_sel6",      op_rd,  8'h0c, 16'd0, 16'd0, 1'b0);
		add_row("wr_sel7",      op_wr,  8'h0e, 16'd1, 16'd0, 1'b0);
		add_row("wr_sel8",      op_wr,  8'h10, 16'd7, 16'd0, 1'b0);
		add_row("wr_sel9",      op_wr,  8'h12, 16'd10, 16'd0, 1'b0);
		add_row("rd_sel9",      op_rd,  8'h12, 16'd0, 16'd10, 1'b0);
		for (int k = 0; k < 8; k++)
			add_row($sformatf("route_%0d", k), op_trig, 8'h00, 16'd0, 16'd0, 1'b0);
		// LEDs, input 4 to one output, input 6 to two
		add_row("wr_sel10",     op_wr,  8'h14, 16'd5, 16'd0, 1'b0);
		add_row("led_in4",      op_led, 8'h04, 16'd0, 16'd0, 1'b0);
		add_row("led_in6",      op_led, 8'h06, 16'd0, 16'd0, 1'b0);

		cycle_limit = t_name.size() * 40 + 200;

		repeat (10) @(negedge apb);
		rst_n = 1'b1;
		@(negedge apb);

		for (int r = 0; r < t_name.size(); r++) begin
			test_err = 0;
			case (t_op[r])
				op_rst: run_reset_row(t_name[r]);
				op_wr: begin
					apb_xfer(t_addr[r], 1'b1, t_data[r], rd, err);
					check_val({t_name[r], " pslverr"}, t_err[r], err);
					// Accepted write updates the expected map
					if (!t_err[r])
						sel_model[t_addr[r] >> 1] = t_data[r][3:0];
				end
				op_rd: begin
					apb_xfer(t_addr[r], 1'b0, '0, rd, err);
					check_val({t_name[r], " pslverr"}, t_err[r], err);
					check_val({t_name[r], " prdata"}, t_exp[r], rd);
				end
				op_trig: run_trig_row(t_name[r]);
				op_led: run_led_row(t_name[r], int'(t_addr[r]));
				default: begin
					err_cnt++;
					$display("Row %s has an unknown operation", t_name[r]);
				end
			endcase
			test_cnt++;
			if (test_err == 0)
				$display("test %s ok", t_name[r]);
			else
				$display("test %s had %0d mismatches", t_name[r], test_err);
		end

		$display("tests %0d  checks %0d  errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== trig_xbar.f ====
apb_defs_pkg.sv
xbar_types_pkg.sv
xbar_apb_regs.sv
xbar_input_stage.sv
xbar_out_channel.sv
xbar_output_stage.sv
trig_xbar_top.sv
tb_trig_xbar.sv

// ==== trig_xbar_top.sv ====
`timescale 1ns/1ps

module trig_xbar_top
	import apb_defs_pkg::*;
	import xbar_types_pkg::*;
(
	input  logic      apb,
	input  logic      rst_n,

	// APB completer
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_data_t pwdata,
	output logic      pready,
	output apb_data_t prdata,
	output logic      pslverr,

	// Trigger pins
	input  port_vec_t trig_in,
	output port_vec_t trig_out,

	// Indicator LEDs
	output port_vec_t trig_in_led,
	output port_vec_t trig_out_led
);

	//////////////////////////////////////////////////
	// Internal nets

	// Per-output selects from the register block
	muxsel_t [num_ports-1:0] muxsel;

	// Inputs after the synchronizer
	port_vec_t               trig_sync;

	// Channel results before the LED logic
	port_vec_t               trig_routed;

	//////////////////////////////////////////////////
	// Register block

	xbar_apb_regs u_regs (
		.apb     (apb),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.pready  (pready),
		.prdata  (prdata),
		.pslverr (pslverr),
		.muxsel  (muxsel)
	);

	//////////////////////////////////////////////////
	// Input side

	xbar_input_stage u_in (
		.apb         (apb),
		.rst_n       (rst_n),
		.trig_in     (trig_in),
		.trig_sync   (trig_sync),
		.trig_in_led (trig_in_led)
	);

	//////////////////////////////////////////////////
	// Switch matrix, one lane per output

	for (genvar i = 0; i < num_ports; i++) begin : g_chan
		xbar_out_channel u_chan (
			.apb       (apb),
			.rst_n     (rst_n),
			.sel       (muxsel[i]),
			.trig_sync (trig_sync),
			.trig      (trig_routed[i])
		);
	end

	//////////////////////////////////////////////////
	// Output side

	xbar_output_stage u_out (
		.apb          (apb),
		.rst_n        (rst_n),
		.trig_routed  (trig_routed),
		.trig_out     (trig_out),
		.trig_out_led (trig_out_led)
	);

endmodule

// ==== xbar_apb_regs.sv ====
`timescale 1ns/1ps

module xbar_apb_regs
	import apb_defs_pkg::*;
	import xbar_types_pkg::*;
(
	input  logic                        apb,
	input  logic                        rst_n,

	// APB completer
	input  apb_addr_t                   paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  apb_data_t                   pwdata,
	output logic                        pready,
	output apb_data_t                   prdata,
	output logic                        pslverr,

	// One select per output channel
	output muxsel_t [num_ports-1:0]     muxsel
);

	//////////////////////////////////////////////////
	// Address decode

	// Access phase of a transfer
	logic      access;

	// Raw index from the upper address bits
	apb_addr_t port_idx;

	// Index narrowed to the register array
	port_idx_t reg_idx;

	logic      addr_unaligned;
	logic      idx_bad;
	logic      data_bad;
	logic      write_ok;

	assign access = psel && penable;

	assign port_idx = paddr >> reg_idx_lsb;
	assign reg_idx  = port_idx[port_idx_width-1:0];

	// Low byte-lane bits must be clear
	assign addr_unaligned = |paddr[reg_idx_lsb-1:0];

	// Beyond the last output
	assign idx_bad = (port_idx >= apb_addr_t'(num_ports));

	// Only off or a real input may be stored
	assign data_bad = pwrite && (pwdata > apb_data_t'(num_ports));

	assign write_ok = access && pwrite && !addr_unaligned && !idx_bad && !data_bad;

	//////////////////////////////////////////////////
	// Response without wait states

	always_comb begin
		pready  = access;
		pslverr = access && (addr_unaligned || idx_bad || data_bad);
		prdata  = '0;

		// Readback only on a clean read
		if (access && !pwrite && !addr_unaligned && !idx_bad)
			prdata = apb_data_t'(muxsel[reg_idx]);
	end

	//////////////////////////////////////////////////
	// Select registers

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			// All outputs off
			for (int i = 0; i < num_ports; i++)
				muxsel[i] <= muxsel_off;
		end else if (write_ok) begin
			muxsel[reg_idx] <= pwdata[$bits(muxsel_t)-1:0];
		end
	end

	//////////////////////////////////////////////////
	// Checks

	// Access phase only ever follows a setup phase
	a_pready_psel: assert property (@(posedge apb) disable iff (!rst_n)
		pready |-> (psel && $past(psel && !penable)))
		else $error("pready without a preceding APB setup phase");

	// Stored selects always name an existing input
	for (genvar i = 0; i < num_ports; i++) begin : g_sel_chk
		a_sel_range: assert property (@(posedge apb) disable iff (!rst_n)
			muxsel[i] <= muxsel_t'(num_ports))
			else $error("select %0d holds an out-of-range value", i);
	end

endmodule

// ==== xbar_input_stage.sv ====
`timescale 1ns/1ps

module xbar_input_stage
	import xbar_types_pkg::*;
(
	input  logic      apb,
	input  logic      rst_n,

	// Asynchronous trigger inputs
	input  port_vec_t trig_in,

	// Inputs in the apb domain
	output port_vec_t trig_sync,

	// Activity indicators
	output port_vec_t trig_in_led
);

	//////////////////////////////////////////////////
	// Synchronizer

	// Stage 0 samples the pins, last stage feeds the matrix
	port_vec_t sync_q [sync_stages];

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			for (int s = 0; s < sync_stages; s++)
				sync_q[s] <= '0;
		end else begin
			sync_q[0] <= trig_in;
			for (int s = 1; s < sync_stages; s++)
				sync_q[s] <= sync_q[s-1];
		end
	end

	assign trig_sync = sync_q[sync_stages-1];

	//////////////////////////////////////////////////
	// Input LEDs

	// Per-input hold counters
	led_cnt_t led_cnt [num_ports];

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			for (int i = 0; i < num_ports; i++)
				led_cnt[i] <= '0;
		end else begin
			// Reload while high, decay otherwise
			for (int i = 0; i < num_ports; i++)
				led_cnt[i] <= led_cnt_next(led_cnt[i], trig_sync[i]);
		end
	end

	// Lit while any hold time remains
	always_comb begin
		for (int i = 0; i < num_ports; i++)
			trig_in_led[i] = (led_cnt[i] != '0);
	end

endmodule

// ==== xbar_out_channel.sv ====
`timescale 1ns/1ps

module xbar_out_channel
	import xbar_types_pkg::*;
(
	input  logic      apb,
	input  logic      rst_n,

	// Select for this lane, 0 is off
	input  muxsel_t   sel,

	// All synchronized inputs
	input  port_vec_t trig_sync,

	// Registered lane output
	output logic      trig
);

	// Input picked by sel
	logic pick;

	// Off and unknown codes give low
	always_comb begin
		pick = 1'b0;
		for (int k = 0; k < num_ports; k++) begin
			if (sel == muxsel_t'(k + 1))
				pick = trig_sync[k];
		end
	end

	// One cycle through the lane
	always_ff @(posedge apb) begin
		if (!rst_n)
			trig <= 1'b0;
		else
			trig <= pick;
	end

	// Register block only hands out valid selects
	a_sel_valid: assert property (@(posedge apb) disable iff (!rst_n)
		sel <= muxsel_t'(num_ports))
		else $error("channel select %0d out of range", sel);

endmodule

// ==== xbar_output_stage.sv ====
`timescale 1ns/1ps

module xbar_output_stage
	import xbar_types_pkg::*;
(
	input  logic      apb,
	input  logic      rst_n,

	// Registered bits from the channels
	input  port_vec_t trig_routed,

	// Trigger outputs
	output port_vec_t trig_out,

	// Activity indicators
	output port_vec_t trig_out_led
);

	// Channels already register, no extra stage here
	assign trig_out = trig_routed;

	//////////////////////////////////////////////////
	// Output LEDs

	led_cnt_t led_cnt [num_ports];

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			for (int i = 0; i < num_ports; i++)
				led_cnt[i] <= '0;
		end else begin
			// Same hold rule as the inputs
			for (int i = 0; i < num_ports; i++)
				led_cnt[i] <= led_cnt_next(led_cnt[i], trig_routed[i]);
		end
	end

	always_comb begin
		for (int i = 0; i < num_ports; i++)
			trig_out_led[i] = (led_cnt[i] != '0);
	end

endmodule

// ==== xbar_types_pkg.sv ====
package xbar_types_pkg;

	//////////////////////////////////////////////////
	// Crossbar geometry

	// Inputs and outputs
	localparam int num_ports = 12;

	// Bits needed to name one port
	localparam int port_idx_width = $clog2(num_ports);

	typedef logic [port_idx_width-1:0] port_idx_t;

	// 0 is off, k routes input k-1
	typedef logic [3:0] muxsel_t;

	localparam muxsel_t muxsel_off = 4'd0;

	// One bit per trigger port
	typedef logic [num_ports-1:0] port_vec_t;

	//////////////////////////////////////////////////
	// Synchronizer and LEDs

	localparam int sync_stages = 2;

	// LED stays lit this many cycles after activity
	localparam int led_hold = 16;

	typedef logic [4:0] led_cnt_t;

	// Hold counter step, reload on activity and decay to zero otherwise
	function automatic led_cnt_t led_cnt_next(input led_cnt_t cnt, input logic active);
		led_cnt_t nxt;
		nxt = cnt;
		if (active)
			nxt = led_cnt_t'(led_hold);
		else if (cnt != '0)
			nxt = cnt - 1'b1;
		return nxt;
	endfunction

endpackage
